/* tb.f */
+incdir+.
llc_cfg_pkg.sv
llc_cfg_regs.sv
llc_flush_fsm.sv
llc_flush_line_seq.sv
llc_bypass_decode.sv
llc_cfg_top.sv
tb_llc_cfg.sv

/* Bender.yml */
package:
  name: llc_cfg

export_include_dirs:
  - .

sources:
  # Design, package first
  - files:
      - llc_cfg_pkg.sv
      - llc_cfg_regs.sv
      - llc_flush_fsm.sv
      - llc_flush_line_seq.sv
      - llc_bypass_decode.sv
      - llc_cfg_top.sv
  # Testbench
  - target: test
    files:
      - tb_llc_cfg.sv

/* tb_llc_cfg.sv */
// Directed tests for llc_cfg_top; the tests share register state and only pass in the order run
`timescale 1ns/1ps
`include "llc_cfg_consts.svh"
`default_nettype none

module tb_llc_cfg import llc_cfg_pkg::*; ();

  localparam int    timeout_cycles = 3000;
  localparam int    line_count     = `LLC_NUM_LINES;
  localparam addr_t cached_addr    = 32'h8000_1000;
  localparam addr_t spm_addr       = 32'h1000_0040;
  localparam addr_t outside_addr   = 32'h4000_0000;

  logic                  clk = 1'b0;
  logic                  arst_n;
  reg_req_t              reg_req;
  logic [`LLC_REG_W-1:0] reg_rdata;
  way_mask_t             bist_res;
  logic                  bist_valid;
  flush_desc_t           desc;
  logic                  desc_valid;
  logic                  desc_ready;
  logic                  flush_done;
  logic                  llc_isolate;
  logic                  llc_isolated;
  logic                  aw_busy;
  logic                  ar_busy;
  addr_t                 aw_addr;
  addr_t                 ar_addr;
  region_rule_t          cached_rule;
  region_rule_t          spm_rule;
  logic                  aw_bypass;
  logic                  ar_bypass;
  way_mask_t             spm_lock;
  way_mask_t             flushed;

  // Reference model state and expected way order
  way_mask_t   model_spm;
  way_mask_t   model_flushed;
  way_mask_t   exp_ways[$];
  // Descriptor port bookkeeping
  int          accepted;
  int          outstanding;
  logic        held_valid;
  flush_desc_t held_desc;
  logic [15:0] lfsr_q;

  always #5 clk = ~clk;

  llc_cfg_top dut (
    .clk_i           ( clk          ),
    .arst_n_i        ( arst_n       ),
    .reg_req_i       ( reg_req      ),
    .reg_rdata_o     ( reg_rdata    ),
    .bist_res_i      ( bist_res     ),
    .bist_valid_i    ( bist_valid   ),
    .desc_o          ( desc         ),
    .desc_valid_o    ( desc_valid   ),
    .desc_ready_i    ( desc_ready   ),
    .flush_done_i    ( flush_done   ),
    .llc_isolate_o   ( llc_isolate  ),
    .llc_isolated_i  ( llc_isolated ),
    .aw_unit_busy_i  ( aw_busy      ),
    .ar_unit_busy_i  ( ar_busy      ),
    .slv_aw_addr_i   ( aw_addr      ),
    .slv_ar_addr_i   ( ar_addr      ),
    .cached_rule_i   ( cached_rule  ),
    .spm_rule_i      ( spm_rule     ),
    .mst_aw_bypass_o ( aw_bypass    ),
    .mst_ar_bypass_o ( ar_bypass    ),
    .spm_lock_o      ( spm_lock     ),
    .flushed_o       ( flushed      )
  );

  //////////////////////////////////////////////////
  // Random bits and expected values
  //////////////////////////////////////////////////
  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  function automatic logic take_rand_bit();
    lfsr_q = lfsr_step(lfsr_q);
    return lfsr_q[0];
  endfunction

  // One line is 4 blocks of 8 bytes
  function automatic flush_desc_t expected_desc(input way_mask_t way, input int line);
    flush_desc_t d;
    d.addr    = addr_t'(line * `LLC_NUM_BLOCKS * (1 << `LLC_BYTE_OFS_W));
    d.len     = 8'(`LLC_NUM_BLOCKS - 1);
    d.size    = 3'(`LLC_BLOCK_SIZE_CODE);
    d.burst   = 2'(`LLC_BURST_INCR);
    d.way_ind = way;
    d.flush   = 1'b1;
    return d;
  endfunction

  function automatic way_mask_t lowest_way(input way_mask_t m);
    way_mask_t r;
    r = '0;
    for (int i = `LLC_NUM_WAYS - 1; i >= 0; i--) begin
      if (m[i]) begin
        r = way_mask_t'(1) << i;
      end
    end
    return r;
  endfunction

  // INIT and END rules with one way per pass
  task automatic model_commit(input way_mask_t flush_req);
    way_mask_t pend;
    way_mask_t way;
    logic      running;
    exp_ways.delete();
    running = 1'b1;
    while (running) begin
      if (flush_req != '0) begin
        pend = flush_req & ~model_flushed;
      end else begin
        pend          = model_spm & ~model_flushed;
        model_flushed = model_spm & model_flushed;
      end
      if (pend == '0) begin
        running = 1'b0;
      end else begin
        way = lowest_way(pend);
        exp_ways.push_back(way);
        if (pend == way) begin
          model_flushed = model_spm;
          running       = 1'b0;
        end else begin
          model_flushed = model_flushed | way;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_mask(input way_mask_t got, input way_mask_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_desc(input flush_desc_t got, input flush_desc_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_reg(input logic [`LLC_REG_W-1:0] got,
                           input logic [`LLC_REG_W-1:0] exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("FAIL at %0t: %s reads %h, expected %h", $time, what, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Bus helpers
  //////////////////////////////////////////////////
  task automatic reg_write(input int offs, input logic [`LLC_REG_W-1:0] data);
    @(negedge clk);
    reg_req.we    = 1'b1;
    reg_req.addr  = `LLC_REG_ADDR_W'(offs);
    reg_req.wdata = data;
    @(negedge clk);
    reg_req.we    = 1'b0;
  endtask

  // Read data is combinational and sampled just after the address settles
  task automatic reg_expect(input int offs, input logic [`LLC_REG_W-1:0] exp, input string what);
    @(negedge clk);
    reg_req.addr = `LLC_REG_ADDR_W'(offs);
    #1;
    check_reg(reg_rdata, exp, what);
  endtask

  task automatic check_bypass(input addr_t aw_a, input addr_t ar_a, input logic exp_aw,
                              input logic exp_ar, input string what);
    @(negedge clk);
    aw_addr = aw_a;
    ar_addr = ar_a;
    #1;
    check_bit(aw_bypass, exp_aw, {"AW bypass, ", what});
    check_bit(ar_bypass, exp_ar, {"AR bypass, ", what});
  endtask

  task automatic wait_isolate(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (llc_isolate !== level) begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout_cycles) begin
        report_failure($sformatf("Isolate never went to %0b %s", level, what));
      end
    end
  endtask

  // One falling edge of the descriptor port where completions lag their transfers
  task automatic service_desc_port(input logic backpressure);
    logic take;
    logic reply;
    reply = (outstanding > 0);
    if (reply && backpressure) begin
      reply = take_rand_bit();
    end
    flush_done = reply;
    if (reply) begin
      outstanding--;
    end
    if (held_valid) begin
      check_bit(desc_valid, 1'b1, "valid under back-pressure");
      check_desc(desc, held_desc, "descriptor under back-pressure");
    end
    take       = backpressure ? take_rand_bit() : 1'b1;
    desc_ready = take;
    held_valid = desc_valid && !take;
    held_desc  = desc;
    if (desc_valid && take) begin
      if (accepted >= exp_ways.size() * line_count) begin
        report_failure("A descriptor arrived that the flush should not produce");
      end else begin
        check_desc(desc, expected_desc(exp_ways[accepted / line_count], accepted % line_count),
                   $sformatf("descriptor %0d", accepted));
        accepted++;
        outstanding++;
      end
    end
  endtask

  // Commit and answer the port until isolation drops
  task automatic run_flush(input logic gate, input logic backpressure);
    int   cycles;
    logic finished;
    accepted    = 0;
    outstanding = 0;
    held_valid  = 1'b0;
    reg_write(`LLC_REG_COMMIT, 1);
    wait_isolate(1'b1, "after commit");
    if (gate) begin
      // Units are idle here so only the missing isolation holds the flush
      repeat (6) begin
        @(negedge clk);
        check_bit(desc_valid, 1'b0, "valid before port isolated");
        check_bit(llc_isolate, 1'b1, "isolate while waiting");
      end
      llc_isolated = 1'b1;
      aw_busy      = 1'b1;
      repeat (6) begin
        @(negedge clk);
        check_bit(desc_valid, 1'b0, "valid while AW unit busy");
      end
      // Each busy unit holds the flush on its own
      aw_busy = 1'b0;
      ar_busy = 1'b1;
      repeat (6) begin
        @(negedge clk);
        check_bit(desc_valid, 1'b0, "valid while AR unit busy");
      end
      ar_busy = 1'b0;
    end else begin
      llc_isolated = 1'b1;
    end
    cycles   = 0;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk);
      if (!llc_isolate) begin
        finished = 1'b1;
      end else begin
        service_desc_port(backpressure);
        cycles++;
        if (cycles > timeout_cycles) begin
          report_failure("The flush did not finish in time");
        end
      end
    end
    desc_ready   = 1'b0;
    flush_done   = 1'b0;
    llc_isolated = 1'b0;
    check_bit(desc_valid, 1'b0, "valid after flush");
    if (accepted != exp_ways.size() * line_count || outstanding != 0) begin
      report_failure($sformatf("FAIL at %0t: %0d descriptors accepted, expected %0d", $time,
                               accepted, exp_ways.size() * line_count));
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic test_bist_init();
    check_bit(llc_isolate, 1'b1, "isolate after reset");
    check_bit(desc_valid, 1'b0, "valid after reset");
    bist_res   = 4'b0010;
    bist_valid = 1'b1;
    @(negedge clk);
    bist_valid = 1'b0;
    model_spm     = 4'b0010;
    model_flushed = 4'b0010;
    wait_isolate(1'b0, "after BIST");
    reg_expect(`LLC_REG_CFG_SPM, `LLC_REG_W'(model_spm), "CFG_SPM");
    reg_expect(`LLC_REG_FLUSHED, `LLC_REG_W'(model_flushed), "FLUSHED");
    reg_expect(`LLC_REG_BIST, `LLC_REG_W'(4'b0010), "BIST");
  endtask

  task automatic test_bypass();
    check_bypass(cached_addr, spm_addr, 1'b0, 1'b0, "ways unflushed");
    check_bypass(outside_addr, cached_addr, 1'b1, 1'b0, "outside region");
    reg_write(`LLC_REG_CFG_SPM, 32'hF);
    model_spm = 4'b1111;
    model_commit('0);
    run_flush(1'b0, 1'b0);
    check_mask(flushed, model_flushed, "flushed_o after full SPM");
    check_bypass(cached_addr, cached_addr + 32'h40, 1'b1, 1'b1, "all ways flushed");
    check_bypass(spm_addr, outside_addr, 1'b0, 1'b1, "SPM and outside, all flushed");
  endtask

  task automatic test_empty_commit();
    reg_write(`LLC_REG_CFG_SPM, 32'h2);
    model_spm = 4'b0010;
    model_commit('0);
    run_flush(1'b0, 1'b0);
    reg_expect(`LLC_REG_FLUSHED, `LLC_REG_W'(model_flushed), "FLUSHED after empty commit");
    reg_expect(`LLC_REG_COMMIT, '0, "COMMIT after empty commit");
  endtask

  task automatic test_explicit_flush();
    reg_write(`LLC_REG_CFG_FLUSH, 32'h5);
    model_commit(4'b0101);
    run_flush(1'b1, 1'b0);
    reg_expect(`LLC_REG_CFG_FLUSH, '0, "CFG_FLUSH after flush");
    reg_expect(`LLC_REG_CFG_SPM, `LLC_REG_W'(model_spm), "CFG_SPM after flush");
    reg_expect(`LLC_REG_FLUSHED, `LLC_REG_W'(model_spm), "FLUSHED after flush");
    reg_expect(`LLC_REG_COMMIT, '0, "COMMIT after flush");
  endtask

  task automatic test_spm_lock();
    reg_write(`LLC_REG_CFG_SPM, 32'hA);
    model_spm = 4'b1010;
    model_commit('0);
    run_flush(1'b0, 1'b0);
    reg_expect(`LLC_REG_FLUSHED, `LLC_REG_W'(model_flushed), "FLUSHED after SPM lock");
    check_mask(spm_lock, model_spm, "spm_lock_o");
  endtask

  task automatic test_backpressure();
    reg_write(`LLC_REG_CFG_FLUSH, 32'h5);
    model_commit(4'b0101);
    run_flush(1'b0, 1'b1);
    reg_expect(`LLC_REG_FLUSHED, `LLC_REG_W'(model_flushed), "FLUSHED after slow flush");
    reg_write(`LLC_REG_CFG_SPM, 32'hF);
    model_spm = 4'b1111;
    model_commit('0);
    run_flush(1'b0, 1'b1);
    check_mask(flushed, model_flushed, "flushed_o after slow SPM flush");
  endtask

  initial begin
    arst_n       = 1'b0;
    reg_req      = '0;
    bist_res     = '0;
    bist_valid   = 1'b0;
    desc_ready   = 1'b0;
    flush_done   = 1'b0;
    llc_isolated = 1'b0;
    aw_busy      = 1'b0;
    ar_busy      = 1'b0;
    aw_addr      = '0;
    ar_addr      = '0;
    // Cached DRAM window and a small SPM window below it
    cached_rule.start_addr = 32'h8000_0000;
    cached_rule.end_addr   = 32'hC000_0000;
    spm_rule.start_addr    = 32'h1000_0000;
    spm_rule.end_addr      = 32'h1001_0000;
    lfsr_q        = 16'd69;
    model_spm     = '0;
    model_flushed = '0;
    held_valid    = 1'b0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    test_bist_init();
    test_bypass();
    test_empty_commit();
    test_explicit_flush();
    test_spm_lock();
    test_backpressure();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* llc_cfg_top.sv */
// Top of the config and flush controller; flush ends when llc_isolate_o returns low
`timescale 1ns/1ps
`include "llc_cfg_consts.svh"
`default_nettype none

module llc_cfg_top import llc_cfg_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  reg_req_t              reg_req_i,
  output logic [`LLC_REG_W-1:0] reg_rdata_o,
  input  way_mask_t             bist_res_i,
  input  logic                  bist_valid_i,
  output flush_desc_t           desc_o,
  output logic                  desc_valid_o,
  input  logic                  desc_ready_i,
  input  logic                  flush_done_i,
  output logic                  llc_isolate_o,
  input  logic                  llc_isolated_i,
  input  logic                  aw_unit_busy_i,
  input  logic                  ar_unit_busy_i,
  input  addr_t                 slv_aw_addr_i,
  input  addr_t                 slv_ar_addr_i,
  input  region_rule_t          cached_rule_i,
  input  region_rule_t          spm_rule_i,
  output logic                  mst_aw_bypass_o,
  output logic                  mst_ar_bypass_o,
  output way_mask_t             spm_lock_o,
  output way_mask_t             flushed_o
);

  cfg_view_t cfg;
  hw_upd_t   hw_upd;
  logic      sw_lock;
  logic      seq_start;
  way_mask_t cur_way;
  logic      way_done;
  logic      all_flushed;

  // Every way flushed means the cache holds nothing
  assign all_flushed = &cfg.flushed;
  assign spm_lock_o  = cfg.cfg_spm;
  assign flushed_o   = cfg.flushed;

  //////////////////////////////////////////////////
  // Registers, control and sequencer
  //////////////////////////////////////////////////
  llc_cfg_regs i_regs (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .reg_req_i    ( reg_req_i    ),
    .reg_rdata_o  ( reg_rdata_o  ),
    .hw_upd_i     ( hw_upd       ),
    .sw_lock_i    ( sw_lock      ),
    .bist_res_i   ( bist_res_i   ),
    .bist_valid_i ( bist_valid_i ),
    .cfg_o        ( cfg          )
  );

  llc_flush_fsm i_fsm (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .cfg_i          ( cfg            ),
    .bist_res_i     ( bist_res_i     ),
    .bist_valid_i   ( bist_valid_i   ),
    .llc_isolated_i ( llc_isolated_i ),
    .aw_unit_busy_i ( aw_unit_busy_i ),
    .ar_unit_busy_i ( ar_unit_busy_i ),
    .way_done_i     ( way_done       ),
    .hw_upd_o       ( hw_upd         ),
    .sw_lock_o      ( sw_lock        ),
    .llc_isolate_o  ( llc_isolate_o  ),
    .seq_start_o    ( seq_start      ),
    .cur_way_o      ( cur_way        )
  );

  llc_flush_line_seq i_seq (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .start_i      ( seq_start    ),
    .way_i        ( cur_way      ),
    .desc_o       ( desc_o       ),
    .desc_valid_o ( desc_valid_o ),
    .desc_ready_i ( desc_ready_i ),
    .flush_done_i ( flush_done_i ),
    .way_done_o   ( way_done     )
  );

  // Bypass steering, one decoder per address channel
  llc_bypass_decode i_aw_bypass (
    .addr_i        ( slv_aw_addr_i   ),
    .cached_rule_i ( cached_rule_i   ),
    .spm_rule_i    ( spm_rule_i      ),
    .all_flushed_i ( all_flushed     ),
    .bypass_o      ( mst_aw_bypass_o )
  );

  llc_bypass_decode i_ar_bypass (
    .addr_i        ( slv_ar_addr_i   ),
    .cached_rule_i ( cached_rule_i   ),
    .spm_rule_i    ( spm_rule_i      ),
    .all_flushed_i ( all_flushed     ),
    .bypass_o      ( mst_ar_bypass_o )
  );

endmodule

`default_nettype wire

/* llc_bypass_decode.sv */
// Zero-latency region check; overlapping regions resolve in favour of the SPM region
`timescale 1ns/1ps
`default_nettype none

module llc_bypass_decode import llc_cfg_pkg::*; (
  input  addr_t        addr_i,
  input  region_rule_t cached_rule_i,
  input  region_rule_t spm_rule_i,
  input  logic         all_flushed_i,
  output logic         bypass_o
);

  logic spm_hit;
  logic cached_hit;

  // Start inclusive, end exclusive
  assign spm_hit    = (addr_i >= spm_rule_i.start_addr) &&
                      (addr_i < spm_rule_i.end_addr);
  assign cached_hit = (addr_i >= cached_rule_i.start_addr) &&
                      (addr_i < cached_rule_i.end_addr);

  always_comb begin
    if (spm_hit) begin
      // SPM always lives in the cache
      bypass_o = 1'b0;
    end else if (cached_hit) begin
      // Nothing left to cache with, go straight to memory
      bypass_o = all_flushed_i;
    end else begin
      // Unmapped addresses take the bypass
      bypass_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* llc_flush_line_seq.sv */
// Sends lines 0 to 15 of one way in order; expects exactly one completion pulse per sent line
`timescale 1ns/1ps
`include "llc_cfg_consts.svh"
`default_nettype none

module llc_flush_line_seq import llc_cfg_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        start_i,
  input  way_mask_t   way_i,
  output flush_desc_t desc_o,
  output logic        desc_valid_o,
  input  logic        desc_ready_i,
  input  logic        flush_done_i,
  output logic        way_done_o
);

  localparam line_idx_t LastLine = line_idx_t'(`LLC_NUM_LINES - 1);

  way_mask_t way_q;
  line_idx_t line_q;
  line_idx_t recv_q;
  logic      valid_q;
  logic      active_q;
  logic      all_sent;

  // All descriptors of the way have been accepted
  assign all_sent   = active_q && !valid_q;
  // Last completion closes the way
  assign way_done_o = all_sent && flush_done_i && (recv_q == LastLine);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      way_q    <= '0;
      line_q   <= '0;
      recv_q   <= '0;
      valid_q  <= 1'b0;
      active_q <= 1'b0;
    end else if (start_i) begin
      // Way of the running flush
      way_q    <= way_i;
      line_q   <= '0;
      recv_q   <= '0;
      valid_q  <= 1'b1;
      active_q <= 1'b1;
    end else begin
      // Send side advances only on a handshake
      if (valid_q && desc_ready_i) begin
        if (line_q == LastLine) begin
          valid_q <= 1'b0;
        end else begin
          line_q <= line_q + line_idx_t'(1);
        end
      end
      // Completions overlap with sending
      if (active_q && flush_done_i) begin
        recv_q <= recv_q + line_idx_t'(1);
      end
      if (way_done_o) begin
        active_q <= 1'b0;
      end
    end
  end

  // Descriptor built from registers only so it holds under back-pressure
  assign desc_valid_o   = valid_q;
  assign desc_o.addr    = addr_t'(line_q) << (`LLC_BLOCK_OFS_W + `LLC_BYTE_OFS_W);
  assign desc_o.len     = 8'(`LLC_NUM_BLOCKS - 1);
  assign desc_o.size    = 3'(`LLC_BLOCK_SIZE_CODE);
  assign desc_o.burst   = 2'(`LLC_BURST_INCR);
  assign desc_o.way_ind = way_q;
  assign desc_o.flush   = 1'b1;

  a_desc_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    desc_valid_o && !desc_ready_i |=> desc_valid_o && $stable(desc_o));

endmodule

`default_nettype wire

/* llc_flush_fsm.sv */
// One flush at a time, one way at a time; starts in PRE_INIT and waits for a BIST result
`timescale 1ns/1ps
`default_nettype none

module llc_flush_fsm import llc_cfg_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  cfg_view_t cfg_i,
  // BIST result maps faulty ways as SPM
  input  way_mask_t bist_res_i,
  input  logic      bist_valid_i,
  // Port isolation and splitter status
  input  logic      llc_isolated_i,
  input  logic      aw_unit_busy_i,
  input  logic      ar_unit_busy_i,
  // From the line sequencer
  input  logic      way_done_i,
  output hw_upd_t   hw_upd_o,
  output logic      sw_lock_o,
  output logic      llc_isolate_o,
  output logic      seq_start_o,
  output way_mask_t cur_way_o
);

  flush_state_e state_q, state_d;
  // Ways still waiting for their flush
  way_mask_t    to_flush_q, to_flush_d;
  way_mask_t    pend;

  //////////////////////////////////////////////////
  // State and pending mask registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= PRE_INIT;
      to_flush_q <= '0;
    end else begin
      state_q    <= state_d;
      to_flush_q <= to_flush_d;
    end
  end

  // Lowest pending way, one-hot
  assign cur_way_o = to_flush_q & (~to_flush_q + way_mask_t'(1));

  // Normal operation only in IDLE
  assign sw_lock_o     = (state_q != IDLE);
  assign llc_isolate_o = (state_q != IDLE);

  // INIT mask, explicit flush has priority over SPM configuration
  assign pend = (|cfg_i.cfg_flush) ? (cfg_i.cfg_flush & ~cfg_i.flushed)
                                   : (cfg_i.cfg_spm & ~cfg_i.flushed);

  //////////////////////////////////////////////////
  // Next state and register updates
  //////////////////////////////////////////////////
  always_comb begin
    state_d     = state_q;
    to_flush_d  = to_flush_q;
    hw_upd_o    = '0;
    seq_start_o = 1'b0;
    unique case (state_q)
      PRE_INIT: begin
        // Faulty ways become SPM and count as flushed, no flush runs
        if (bist_valid_i) begin
          hw_upd_o.spm_we      = 1'b1;
          hw_upd_o.spm_val     = bist_res_i;
          hw_upd_o.flushed_we  = 1'b1;
          hw_upd_o.flushed_val = bist_res_i;
          state_d              = IDLE;
        end
      end
      IDLE: begin
        if (cfg_i.commit) begin
          hw_upd_o.commit_clear = 1'b1;
          state_d               = WAIT_AX;
        end
      end
      WAIT_AX: begin
        // Slave port must be quiet first
        if (llc_isolated_i) begin
          state_d = WAIT_UNITS;
        end
      end
      WAIT_UNITS: begin
        if (!aw_unit_busy_i && !ar_unit_busy_i) begin
          state_d = INIT;
        end
      end
      INIT: begin
        // SPM path drops flushed bits of ways no longer locked
        if (!(|cfg_i.cfg_flush)) begin
          hw_upd_o.flushed_we  = 1'b1;
          hw_upd_o.flushed_val = cfg_i.cfg_spm & cfg_i.flushed;
        end
        if (pend == '0) begin
          hw_upd_o.flush_clear = 1'b1;
          state_d              = IDLE;
        end else begin
          to_flush_d = pend;
          state_d    = SEND;
        end
      end
      SEND: begin
        // Single start pulse for the lowest pending way
        seq_start_o = 1'b1;
        state_d     = WAIT_DONE;
      end
      WAIT_DONE: begin
        if (way_done_i) begin
          state_d = END;
        end
      end
      END: begin
        if (to_flush_q == cur_way_o) begin
          // Last way, flushed falls back to the SPM ways
          hw_upd_o.flushed_we  = 1'b1;
          hw_upd_o.flushed_val = cfg_i.cfg_spm;
          hw_upd_o.flush_clear = 1'b1;
          to_flush_d           = '0;
          state_d              = IDLE;
        end else begin
          hw_upd_o.flushed_we  = 1'b1;
          hw_upd_o.flushed_val = cfg_i.flushed | cur_way_o;
          state_d              = INIT;
        end
      end
      default: state_d = PRE_INIT;
    endcase
  end

  // Sequencer gets exactly one way per start
  a_start_onehot : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) seq_start_o |-> $onehot(cur_way_o));

  // Port stays isolated until the sequencer reports the way done
  a_isolate_held : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    seq_start_o |=> llc_isolate_o throughout (way_done_i [->1]));

endmodule

`default_nettype wire

/* llc_cfg_regs.sv */
// Register file with async reset; unknown offsets read zero and SPM/flush writes drop while locked
`timescale 1ns/1ps
`include "llc_cfg_consts.svh"
`default_nettype none

module llc_cfg_regs import llc_cfg_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Software port
  input  reg_req_t              reg_req_i,
  output logic [`LLC_REG_W-1:0] reg_rdata_o,
  // Hardware port from the flush FSM
  input  hw_upd_t               hw_upd_i,
  input  logic                  sw_lock_i,
  // Tag storage BIST result
  input  way_mask_t             bist_res_i,
  input  logic                  bist_valid_i,
  output cfg_view_t             cfg_o
);

  way_mask_t cfg_spm_q;
  way_mask_t cfg_flush_q;
  way_mask_t flushed_q;
  way_mask_t bist_q;
  logic      commit_q;

  // Decoded software writes
  logic wr_spm;
  logic wr_flush;
  logic wr_commit;

  // SPM and flush masks are frozen for software during a flush
  assign wr_spm    = reg_req_i.we && !sw_lock_i &&
                     (reg_req_i.addr == `LLC_REG_ADDR_W'(`LLC_REG_CFG_SPM));
  assign wr_flush  = reg_req_i.we && !sw_lock_i &&
                     (reg_req_i.addr == `LLC_REG_ADDR_W'(`LLC_REG_CFG_FLUSH));
  // Commit only ever gets set by software
  assign wr_commit = reg_req_i.we && reg_req_i.wdata[0] &&
                     (reg_req_i.addr == `LLC_REG_ADDR_W'(`LLC_REG_COMMIT));

  //////////////////////////////////////////////////
  // Register update, hardware first
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_spm_q   <= '0;
      cfg_flush_q <= '0;
      flushed_q   <= '0;
      bist_q      <= '0;
      commit_q    <= 1'b0;
    end else begin
      if (hw_upd_i.spm_we) begin
        cfg_spm_q <= hw_upd_i.spm_val;
      end else if (wr_spm) begin
        cfg_spm_q <= reg_req_i.wdata[`LLC_NUM_WAYS-1:0];
      end
      if (hw_upd_i.flush_clear) begin
        cfg_flush_q <= '0;
      end else if (wr_flush) begin
        cfg_flush_q <= reg_req_i.wdata[`LLC_NUM_WAYS-1:0];
      end
      // Flushed is read-only for software
      if (hw_upd_i.flushed_we) begin
        flushed_q <= hw_upd_i.flushed_val;
      end
      if (hw_upd_i.commit_clear) begin
        commit_q <= 1'b0;
      end else if (wr_commit) begin
        commit_q <= 1'b1;
      end
      // Last BIST result stays visible
      if (bist_valid_i) begin
        bist_q <= bist_res_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // Combinational read mux
  //////////////////////////////////////////////////
  always_comb begin
    case (reg_req_i.addr)
      `LLC_REG_ADDR_W'(`LLC_REG_CFG_SPM):   reg_rdata_o = `LLC_REG_W'(cfg_spm_q);
      `LLC_REG_ADDR_W'(`LLC_REG_CFG_FLUSH): reg_rdata_o = `LLC_REG_W'(cfg_flush_q);
      `LLC_REG_ADDR_W'(`LLC_REG_COMMIT):    reg_rdata_o = `LLC_REG_W'(commit_q);
      `LLC_REG_ADDR_W'(`LLC_REG_FLUSHED):   reg_rdata_o = `LLC_REG_W'(flushed_q);
      `LLC_REG_ADDR_W'(`LLC_REG_BIST):      reg_rdata_o = `LLC_REG_W'(bist_q);
      default:                              reg_rdata_o = '0;
    endcase
  end

  assign cfg_o.cfg_spm   = cfg_spm_q;
  assign cfg_o.cfg_flush = cfg_flush_q;
  assign cfg_o.flushed   = flushed_q;
  assign cfg_o.commit    = commit_q;

  // The FSM only acknowledges a commit that software actually raised
  a_commit_clear_when_set : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) hw_upd_i.commit_clear |-> commit_q);

endmodule

`default_nettype wire

/* llc_cfg_pkg.sv */
// Types for the LLC configuration and flush controller; widths come from llc_cfg_consts.svh
`include "llc_cfg_consts.svh"
`default_nettype none

package llc_cfg_pkg;

  // One bit per cache way
  typedef logic [`LLC_NUM_WAYS-1:0] way_mask_t;
  // Line index inside one way
  typedef logic [`LLC_INDEX_W-1:0]  line_idx_t;
  typedef logic [`LLC_ADDR_W-1:0]   addr_t;

  // Half-open region, start inclusive and end exclusive
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } region_rule_t;

  // Flush descriptor handed to the cache pipeline
  typedef struct packed {
    addr_t     addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    way_mask_t way_ind;
    logic      flush;
  } flush_desc_t;

  // Software register request, write strobe only
  typedef struct packed {
    logic                       we;
    logic [`LLC_REG_ADDR_W-1:0] addr;
    logic [`LLC_REG_W-1:0]      wdata;
  } reg_req_t;

  // Hardware updates from the flush FSM, these win over software writes
  typedef struct packed {
    logic      flushed_we;
    way_mask_t flushed_val;
    logic      spm_we;
    way_mask_t spm_val;
    logic      flush_clear;
    logic      commit_clear;
  } hw_upd_t;

  // Register contents seen by the FSM
  typedef struct packed {
    way_mask_t cfg_spm;
    way_mask_t cfg_flush;
    way_mask_t flushed;
    logic      commit;
  } cfg_view_t;

  typedef enum logic [2:0] {
    PRE_INIT,
    IDLE,
    WAIT_AX,
    WAIT_UNITS,
    INIT,
    SEND,
    WAIT_DONE,
    END
  } flush_state_e;

endpackage

`default_nettype wire

/* llc_cfg_consts.svh */
// Fixed geometry of 4 ways x 16 lines x 4 blocks of 8 bytes; changing a value needs a matching package review
`ifndef LLC_CFG_CONSTS_SVH
`define LLC_CFG_CONSTS_SVH
`default_nettype none

// Cache geometry
`define LLC_NUM_WAYS        4
`define LLC_NUM_LINES       16
`define LLC_INDEX_W         4
`define LLC_NUM_BLOCKS      4
`define LLC_BLOCK_OFS_W     2
// A block is 8 bytes wide
`define LLC_BYTE_OFS_W      3

// Bus and register widths
`define LLC_ADDR_W          32
`define LLC_REG_W           32
`define LLC_REG_ADDR_W      3

// Register map, word offsets
`define LLC_REG_CFG_SPM     0
`define LLC_REG_CFG_FLUSH   1
`define LLC_REG_COMMIT      2
`define LLC_REG_FLUSHED     3
`define LLC_REG_BIST        4

// AXI encodings used in flush descriptors
`define LLC_BLOCK_SIZE_CODE 3
`define LLC_BURST_INCR      1

`default_nettype wire
`endif
